/* common/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    // address and instruction word.
    localparam int AddrWidth = 32;
    localparam int InstWidth = 32;

    // opcode bit 6 marks a branch or jump.
    localparam int BjBit = 6;

    // direct-mapped cache with one word per line.
    localparam int CacheLines = 16;
    localparam int IndexWidth = $clog2(CacheLines);
    localparam int TagWidth   = AddrWidth - IndexWidth - 2; // byte offset bits dropped.

    // decoder queue slots.
    localparam int CreditWidth = 3;
    localparam logic [CreditWidth-1:0] CreditDepth = CreditWidth'(4);

    // program counter.
    localparam logic [AddrWidth-1:0] ResetPc = '0;
    localparam logic [AddrWidth-1:0] PcStep  = AddrWidth'(4);

    // fetch FSM encoding.
    localparam logic [1:0] FetchIssue = 2'd0; // send the next lookup.
    localparam logic [1:0] FetchWait  = 2'd1; // wait for hit or memory word.
    localparam logic [1:0] FetchHold  = 2'd2; // wait for a redirect.

endpackage

`default_nettype wire

/* common/instLookupIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface instLookupIf ();

    // request from fetch.
    logic                           lookupValid;
    logic [fetchPkg::AddrWidth-1:0] lookupAddr;

    // cache answer.
    logic                           hit;
    logic [fetchPkg::InstWidth-1:0] cacheInst;
    logic                           miss;

    // memory port answer, also the refill data.
    logic                           memValid;
    logic [fetchPkg::InstWidth-1:0] memInst;

    modport fetch (
        output lookupValid, lookupAddr,
        input  hit, cacheInst, memValid, memInst
    );

    modport cache (
        input  lookupValid, lookupAddr, memValid, memInst,
        output hit, cacheInst, miss
    );

    modport memPort (
        input  miss, lookupAddr,
        output memValid, memInst
    );

endinterface

`default_nettype wire

/* fetch/fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
    input  logic                           clk,
    input  logic                           rstN,
    instLookupIf.fetch                     lookup,

    input  logic                           jumpValid,
    input  logic [fetchPkg::AddrWidth-1:0] jumpAddr,
    input  logic                           branchValid,
    input  logic [fetchPkg::AddrWidth-1:0] branchAddr,

    input  logic                           creditReturn,
    output logic                           decValid,
    output logic [fetchPkg::AddrWidth-1:0] decPc,
    output logic [fetchPkg::InstWidth-1:0] decInst
);

    logic [1:0]                       state;
    logic [fetchPkg::AddrWidth-1:0]   pc;
    logic [fetchPkg::CreditWidth-1:0] creditCnt;
    logic                             creditOk;
    logic                             answered;
    logic                             isBj;

    assign creditOk = (creditCnt != '0);

    // a lookup goes out only with a free slot in the decoder queue.
    assign lookup.lookupValid = (state == fetchPkg::FetchIssue) && creditOk;
    assign lookup.lookupAddr  = pc; // held until the answer arrives.

    assign answered = (state == fetchPkg::FetchWait) && (lookup.hit || lookup.memValid);

    // the cache wins when it hits, otherwise the word comes from memory.
    assign decInst  = lookup.hit ? lookup.cacheInst : lookup.memInst;
    assign decPc    = pc;
    assign decValid = answered;

    assign isBj = decInst[fetchPkg::BjBit];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= fetchPkg::FetchIssue;
            pc    <= fetchPkg::ResetPc;
        end else begin
            case (state)
                fetchPkg::FetchIssue: begin
                    if (lookup.lookupValid) begin
                        state <= fetchPkg::FetchWait;
                    end
                end
                fetchPkg::FetchWait: begin
                    if (answered) begin
                        if (isBj) begin
                            state <= fetchPkg::FetchHold; // target not known yet.
                        end else begin
                            state <= fetchPkg::FetchIssue;
                            pc    <= pc + fetchPkg::PcStep;
                        end
                    end
                end
                fetchPkg::FetchHold: begin
                    // jump has priority over branch.
                    if (jumpValid) begin
                        state <= fetchPkg::FetchIssue;
                        pc    <= jumpAddr;
                    end else if (branchValid) begin
                        state <= fetchPkg::FetchIssue;
                        pc    <= branchAddr;
                    end
                end
                default: begin
                    state <= fetchPkg::FetchIssue;
                end
            endcase
        end
    end

    // credit is taken at issue, so a word in flight always has its slot.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= fetchPkg::CreditDepth;
        end else begin
            case ({lookup.lookupValid, creditReturn})
                2'b10: begin
                    creditCnt <= creditCnt - 1'b1;
                end
                2'b01: begin
                    creditCnt <= creditCnt + 1'b1;
                end
                default: begin
                    creditCnt <= creditCnt; // none, or one in and one out.
                end
            endcase
        end
    end

    // the decoder never returns more credits than it was given.
    creditBound: assert property (
        @(posedge clk) disable iff (!rstN)
        creditCnt <= fetchPkg::CreditDepth
    );

    // cache and memory port never answer the same lookup.
    singleAnswer: assert property (
        @(posedge clk) disable iff (!rstN)
        !(lookup.hit && lookup.memValid)
    );

endmodule

`default_nettype wire

/* fetch/instCache.sv */
`timescale 1ns/1ns
`default_nettype none

module instCache (
    input  logic       clk,
    input  logic       rstN,
    instLookupIf.cache lookup
);

    logic [fetchPkg::CacheLines-1:0] lineValid;
    logic [fetchPkg::TagWidth-1:0]   tagMem  [fetchPkg::CacheLines];
    logic [fetchPkg::InstWidth-1:0]  dataMem [fetchPkg::CacheLines];

    logic [fetchPkg::IndexWidth-1:0] lookupIndex;
    logic [fetchPkg::TagWidth-1:0]   lookupTag;

    // registered lookup.
    logic                            reqValid;
    logic [fetchPkg::TagWidth-1:0]   reqTag;
    logic                            readValid;
    logic [fetchPkg::TagWidth-1:0]   readTag;
    logic [fetchPkg::InstWidth-1:0]  readData;
    logic                            tagMatch;

    // word address bits 5 to 2 select the line.
    assign lookupIndex = lookup.lookupAddr[fetchPkg::IndexWidth+1:2];
    assign lookupTag   = lookup.lookupAddr[fetchPkg::AddrWidth-1 -: fetchPkg::TagWidth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqValid  <= 1'b0;
            lineValid <= '0;
        end else begin
            reqValid <= lookup.lookupValid;
            if (lookup.memValid) begin
                lineValid[lookupIndex] <= 1'b1; // refill of the missed line.
            end
        end
    end

    // arrays read and written like a synchronous RAM.
    always_ff @(posedge clk) begin
        if (lookup.lookupValid) begin
            reqTag    <= lookupTag;
            readValid <= lineValid[lookupIndex];
            readTag   <= tagMem[lookupIndex];
            readData  <= dataMem[lookupIndex];
        end
        if (lookup.memValid) begin
            // fetch still holds the missed address here.
            tagMem[lookupIndex]  <= lookupTag;
            dataMem[lookupIndex] <= lookup.memInst;
        end
    end

    assign tagMatch = readValid && (readTag == reqTag);

    assign lookup.hit       = reqValid && tagMatch;
    assign lookup.miss      = reqValid && !tagMatch;
    assign lookup.cacheInst = readData;

    // a refill writes the line of the held address, so no lookup may overlap it.
    refillNoLookup: assert property (
        @(posedge clk) disable iff (!rstN)
        lookup.memValid |-> !lookup.lookupValid
    );

endmodule

`default_nettype wire

/* rtl/fetchTop.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchTop (
    input  logic                           clk,
    input  logic                           rstN,

    // redirects from execute.
    input  logic                           jumpValid,
    input  logic [fetchPkg::AddrWidth-1:0] jumpAddr,
    input  logic                           branchValid,
    input  logic [fetchPkg::AddrWidth-1:0] branchAddr,

    // decoder side.
    input  logic                           creditReturn,
    output logic                           decValid,
    output logic [fetchPkg::AddrWidth-1:0] decPc,
    output logic [fetchPkg::InstWidth-1:0] decInst,

    // external instruction memory.
    output logic                           memReq,
    output logic [fetchPkg::AddrWidth-1:0] memAddr,
    input  logic                           memRespValid,
    input  logic [fetchPkg::InstWidth-1:0] memRespData
);

    instLookupIf lookupBus ();

    fetchUnit fetchUnit_inst (
        .clk          (clk),
        .rstN         (rstN),
        .lookup       (lookupBus),
        .jumpValid    (jumpValid),
        .jumpAddr     (jumpAddr),
        .branchValid  (branchValid),
        .branchAddr   (branchAddr),
        .creditReturn (creditReturn),
        .decValid     (decValid),
        .decPc        (decPc),
        .decInst      (decInst)
    );

    instCache instCache_inst (
        .clk    (clk),
        .rstN   (rstN),
        .lookup (lookupBus)
    );

    instMemPort instMemPort_inst (
        .clk          (clk),
        .rstN         (rstN),
        .lookup       (lookupBus),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .memRespValid (memRespValid),
        .memRespData  (memRespData)
    );

endmodule

`default_nettype wire

/* rtl/instMemPort.sv */
`timescale 1ns/1ns
`default_nettype none

module instMemPort (
    input  logic                           clk,
    input  logic                           rstN,
    instLookupIf.memPort                   lookup,

    output logic                           memReq,
    output logic [fetchPkg::AddrWidth-1:0] memAddr,
    input  logic                           memRespValid,
    input  logic [fetchPkg::InstWidth-1:0] memRespData
);

    logic                           respValid;
    logic [fetchPkg::InstWidth-1:0] respData;
    logic                           respTaken;

    assign respTaken = memReq && memRespValid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memReq    <= 1'b0;
            respValid <= 1'b0;
        end else begin
            respValid <= respTaken; // one-cycle pulse toward fetch and cache.
            if (lookup.miss) begin
                memReq <= 1'b1;
            end else if (respTaken) begin
                memReq <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup.miss) begin
            memAddr <= lookup.lookupAddr; // kept for the whole request.
        end
        if (respTaken) begin
            respData <= memRespData;
        end
    end

    assign lookup.memValid = respValid;
    assign lookup.memInst  = respData;

    // external memory answers only an open request.
    respInRequest: assert property (
        @(posedge clk) disable iff (!rstN)
        memRespValid |-> memReq
    );

    // only one lookup in flight, so no new miss while a read is open.
    singleMiss: assert property (
        @(posedge clk) disable iff (!rstN)
        lookup.miss |-> !memReq && !respValid
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile the fetch front end with its testbench, run it, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f verilog.f --top-module fetchTb -o fetchSim \
    && ./obj_dir/fetchSim > sim.log 2>&1 \
    || echo "build or simulation ended with an error"

cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && exit 0 || exit 1

/* testbench/fetchTb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchTb;

    localparam int ClkPeriod     = 100;
    localparam int NumTests      = 7;
    localparam int CyclesPerTest = 400;
    localparam int CreditMax     = int'(fetchPkg::CreditDepth);
    localparam int BjTimeout     = 300;

    logic                           clk = 1'b0;
    logic                           rstN;
    logic                           jumpValid;
    logic [fetchPkg::AddrWidth-1:0] jumpAddr;
    logic                           branchValid;
    logic [fetchPkg::AddrWidth-1:0] branchAddr;
    logic                           creditReturn = 1'b0;
    logic                           decValid;
    logic [fetchPkg::AddrWidth-1:0] decPc;
    logic [fetchPkg::InstWidth-1:0] decInst;
    logic                           memReq;
    logic [fetchPkg::AddrWidth-1:0] memAddr;
    logic                           memRespValid = 1'b0;
    logic [fetchPkg::InstWidth-1:0] memRespData = '0;

    // model state, written at the falling edge only.
    logic [31:0]                    lfsr = 32'h9f48;
    logic [fetchPkg::AddrWidth-1:0] expPc = fetchPkg::ResetPc;
    logic                           waitingRedirect = 1'b0;
    logic                           rstWasLow = 1'b0;
    logic                           memBusy = 1'b0;
    int                             memDelay = 0;
    int                             stretchLeft = 0;
    int                             delivered = 0;
    int                             returned = 0;

    // test controls.
    logic                           creditHold;
    logic                           hitPhase;
    string                          testName = "none";
    int                             errorCount = 0;
    int                             testStartErrors = 0;
    int                             testsRun = 0;
    int                             testsFailed = 0;

    fetchTop fetchTop_inst (
        .clk          (clk),
        .rstN         (rstN),
        .jumpValid    (jumpValid),
        .jumpAddr     (jumpAddr),
        .branchValid  (branchValid),
        .branchAddr   (branchAddr),
        .creditReturn (creditReturn),
        .decValid     (decValid),
        .decPc        (decPc),
        .decInst      (decInst),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .memRespValid (memRespValid),
        .memRespData  (memRespData)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic takeBits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr  = lfsrStep(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // address as data, bit 6 marks a branch or jump at word index 7 mod 8.
    function automatic logic [31:0] memWord(input logic [31:0] addr);
        logic [31:0] word;
        word = addr;
        word[fetchPkg::BjBit] = (addr[4:2] == 3'd7);
        return word;
    endfunction

    task automatic reportMismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("FAIL %s %s expected %h actual %h at %0t", testName, what, expected, actual,
                 $time);
    endtask

    task automatic reportFault(input string what);
        errorCount++;
        $display("ERROR in %s: %s at %0t", testName, what, $time);
    endtask

    always @(negedge clk) begin : modelStep
        logic [31:0] expWord;
        logic [31:0] bits;
        if (!rstN) begin
            assert (!decValid && !memReq)
                else reportFault("decValid or memReq high during reset");
            rstWasLow       = 1'b1;
            expPc           = fetchPkg::ResetPc;
            waitingRedirect = 1'b0;
            memBusy         = 1'b0;
            stretchLeft     = 0;
            delivered       = 0;
            returned        = 0;
            memRespValid <= 1'b0;
            creditReturn <= 1'b0;
        end else begin
            if (rstWasLow) begin
                assert (!decValid && !memReq)
                    else reportFault("decValid or memReq high in the first cycle after reset");
                rstWasLow = 1'b0;
            end
            if (creditReturn) begin
                returned++;
            end
            if (waitingRedirect) begin
                assert (!memReq) else reportFault("memReq while waiting for a redirect");
            end
            if (hitPhase) begin
                assert (!memReq) else reportFault("memReq on a line that should hit");
            end
            if (memReq) begin
                assert (memAddr == expPc) else reportMismatch("memAddr", expPc, memAddr);
            end
            if (decValid) begin
                delivered++;
                assert (!waitingRedirect) else reportFault("decValid while waiting for a redirect");
                assert (decPc == expPc) else reportMismatch("decPc", expPc, decPc);
                expWord = memWord(expPc);
                assert (decInst == expWord) else reportMismatch("decInst", expWord, decInst);
                if (expWord[fetchPkg::BjBit]) begin
                    waitingRedirect = 1'b1;
                end else begin
                    expPc = expPc + 32'd4;
                end
            end else if (waitingRedirect && (jumpValid || branchValid)) begin
                expPc           = jumpValid ? jumpAddr : branchAddr; // jump wins.
                waitingRedirect = 1'b0;
            end
            assert (delivered - returned <= CreditMax)
                else reportFault($sformatf("%0d instructions outstanding, limit is %0d",
                                           delivered - returned, CreditMax));

            // external memory answers after 1 to 4 cycles.
            if (memRespValid) begin
                memRespValid <= 1'b0;
                memBusy = 1'b0;
            end else if (memReq) begin
                if (!memBusy) begin
                    memBusy = 1'b1;
                    takeBits(2, bits);
                    memDelay = int'(bits) + 1;
                end
                memDelay--;
                if (memDelay == 0) begin
                    memRespValid <= 1'b1;
                    memRespData  <= memWord(memAddr);
                end
            end

            // decoder consumes one word per cycle, with random pauses.
            if (stretchLeft > 0) begin
                stretchLeft--;
            end else begin
                takeBits(2, bits);
                if (bits == 32'd0) begin
                    takeBits(3, bits);
                    stretchLeft = int'(bits) + 2;
                end
            end
            creditReturn <= !creditHold && (stretchLeft == 0) && (delivered - returned > 0);
        end
    end

    task automatic startTest(input string name);
        @(posedge clk);
        testName        = name;
        testStartErrors = errorCount;
    endtask

    task automatic finishTest();
        int newErrors;
        newErrors = errorCount - testStartErrors;
        testsRun++;
        if (newErrors == 0) begin
            $display("test %-14s ok", testName);
        end else begin
            testsFailed++;
            $display("test %-14s failed with %0d errors", testName, newErrors);
        end
    endtask

    task automatic waitForBranchOrJump();
        int cycles;
        cycles = 0;
        @(posedge clk); // the model has seen a redirect from the last falling edge.
        while (!waitingRedirect && cycles < BjTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!waitingRedirect) begin
            reportFault($sformatf("no branch or jump delivered within %0d cycles", BjTimeout));
        end
    endtask

    // one-cycle redirect, given while fetch waits.
    task automatic sendRedirect(input logic jump, input logic [31:0] jAddr,
                                input logic branch, input logic [31:0] bAddr);
        @(negedge clk);
        jumpValid   <= jump;
        jumpAddr    <= jAddr;
        branchValid <= branch;
        branchAddr  <= bAddr;
        @(negedge clk);
        jumpValid   <= 1'b0;
        branchValid <= 1'b0;
    endtask

    initial begin
        rstN        <= 1'b0;
        jumpValid   <= 1'b0;
        jumpAddr    <= '0;
        branchValid <= 1'b0;
        branchAddr  <= '0;
        creditHold  <= 1'b0;
        hitPhase    <= 1'b0;

        startTest("reset");
        repeat (4) @(negedge clk);
        rstN <= 1'b1;
        repeat (2) @(negedge clk);
        finishTest();

        startTest("sequential");
        waitForBranchOrJump(); // runs 0 to 28.
        finishTest();

        startTest("branchWait");
        repeat (20) @(negedge clk);
        sendRedirect(1'b0, 32'h0, 1'b1, 32'h200);
        waitForBranchOrJump();
        finishTest();

        startTest("jumpPriority");
        sendRedirect(1'b1, 32'h420, 1'b1, 32'h600); // lines 8 to 15.
        waitForBranchOrJump();
        finishTest();

        startTest("cacheHit");
        @(negedge clk);
        hitPhase <= 1'b1;
        sendRedirect(1'b0, 32'h0, 1'b1, 32'h200);
        waitForBranchOrJump();
        @(negedge clk);
        hitPhase <= 1'b0;
        finishTest();

        startTest("credits");
        @(negedge clk);
        creditHold <= 1'b1;
        sendRedirect(1'b1, 32'h800, 1'b0, 32'h0);
        repeat (80) @(posedge clk);
        assert (delivered - returned == CreditMax)
            else reportMismatch("outstanding", 32'(CreditMax), 32'(delivered - returned));
        @(negedge clk);
        creditHold <= 1'b0;
        waitForBranchOrJump();
        finishTest();

        startTest("midReset");
        sendRedirect(1'b0, 32'h0, 1'b1, 32'h40);
        repeat (3) @(negedge clk);
        rstN <= 1'b0;
        repeat (4) @(negedge clk);
        rstN <= 1'b1;
        waitForBranchOrJump(); // fetch starts again at the reset PC.
        finishTest();

        $display("tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(NumTests * CyclesPerTest * ClkPeriod);
        $display("watchdog: run did not finish within %0d cycles",
                 NumTests * CyclesPerTest);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/fetchPkg.sv
common/instLookupIf.sv
fetch/fetchUnit.sv
fetch/instCache.sv
rtl/instMemPort.sv
rtl/fetchTop.sv
testbench/fetchTb.sv
